// ==== all.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/mem_req_if.sv
rtl/local_port.sv
rtl/atomic_alu.sv
rtl/global_seq.sv
rtl/wb_mux.sv
rtl/lsu_top.sv
dv/lsu_assertions.sv
dv/lsu_tb.sv

// ==== dv/lsu_assertions.sv ====
`timescale 1ns/1ns

module lsu_assertions (
    input logic           clk,
    input logic           rst_n,
    input logic           valid_in,
    input logic           stall_pipeline,
    input logic           wb_valid,
    input logic           global_req_valid,
    input logic           global_req_ready,
    input logic           global_req_is_load,
    input lsu_pkg::addr_t global_req_addr,
    input lsu_pkg::word_t global_req_wdata
);
    int unsigned violations = 0;

    // Request fields hold until the memory side takes them
    req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        global_req_valid && !global_req_ready |=> global_req_valid
            && $stable(global_req_is_load) && $stable(global_req_addr)
            && $stable(global_req_wdata))
        else begin
            violations++;
            $error("Global request changed while waiting for ready");
        end

    no_wb_in_reset_a: assert property (@(posedge clk) !rst_n |-> !wb_valid)
        else begin
            violations++;
            $error("Writeback asserted during reset");
        end

    // A request that is not taken yet keeps the pipeline held
    stall_on_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        global_req_valid && valid_in && !global_req_ready |-> stall_pipeline)
        else begin
            violations++;
            $error("Pipeline not stalled on a pending global request");
        end

endmodule

bind lsu_top lsu_assertions sva_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .valid_in           (valid_in),
    .stall_pipeline     (stall_pipeline),
    .wb_valid           (wb_valid),
    .global_req_valid   (global_req_valid),
    .global_req_ready   (global_req_ready),
    .global_req_is_load (global_req_is_load),
    .global_req_addr    (global_req_addr),
    .global_req_wdata   (global_req_wdata)
);

// ==== dv/lsu_tb.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int CLK_PERIOD       = 20;
    localparam int RESET_CYCLES     = 16;
    localparam int CYCLES_PER_ENTRY = 40;

    typedef struct packed {
        logic       is_store;
        logic       is_atomic;
        mem_size_e  size;
        atomic_op_e op;
        addr_t      addr;
        word_t      wdata;
        reg_idx_t   dest;
        word_t      expected;   // Writeback value of loads and atomics
    } entry_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       valid_in;
    logic       is_store;
    logic       is_atomic;
    mem_size_e  size;
    atomic_op_e atomic_op;
    addr_t      addr;
    word_t      write_data;
    reg_idx_t   dest_reg_idx;
    logic       stall_pipeline;
    logic       busy;
    logic       local_req_valid;
    logic       local_we;
    addr_t      local_addr;
    line_t      local_wdata;
    logic [1:0] local_bank_sel;
    line_t      local_rdata;
    logic       global_req_valid;
    logic       global_req_is_load;
    addr_t      global_req_addr;
    word_t      global_req_wdata;
    logic       global_req_ready;
    logic       global_resp_valid;
    word_t      global_resp_data;
    logic       wb_valid;
    reg_idx_t   wb_reg_idx;
    word_t      wb_data;

    entry_t      stim_q[$];
    logic        table_ready = 1'b0;
    line_t       lmem [16];
    word_t       gmem [64];
    line_t       lread_line;
    word_t       resp_word;
    int          resp_wait;
    logic        ready_next = 1'b0;
    logic        resp_valid_next = 1'b0;
    logic [31:0] lfsr_state = 32'hfca0_455f;
    int          checks = 0;
    int          errors = 0;

    lsu_top dut_i (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    // ------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        logic [1:0] delay_bits;
        if (local_req_valid) begin
            if (local_we) begin
                lmem[local_addr[7:4]][local_bank_sel*`LSU_DATA_W +: `LSU_DATA_W] =
                    local_wdata[local_bank_sel*`LSU_DATA_W +: `LSU_DATA_W];
            end else begin
                lread_line = lmem[local_addr[7:4]];  // Shows up on the next falling edge
            end
        end
        if (global_req_valid && global_req_ready) begin
            if (global_req_is_load) begin
                resp_word     = gmem[global_req_addr[7:2]];
                delay_bits[0] = next_bit();
                delay_bits[1] = next_bit();
                resp_wait     = 1 + int'(delay_bits);  // 1 to 4 cycles
            end else begin
                gmem[global_req_addr[7:2]] = global_req_wdata;
            end
        end
        // Handshake inputs for the cycle that starts at the next falling edge
        ready_next      = next_bit() | next_bit();  // Ready about three cycles in four
        resp_valid_next = 1'b0;
        if (resp_wait > 0) begin
            resp_wait       = resp_wait - 1;
            resp_valid_next = (resp_wait == 0);
        end
    end

    always @(negedge clk) begin
        local_rdata       = lread_line;
        global_req_ready  = ready_next;
        global_resp_valid = resp_valid_next;
        global_resp_data  = resp_word;
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic flag_entry(input int i, input string what);
        errors++;
        $display("Entry %0d: %s", i, what);
    endtask

    task automatic add_entry(input logic st, input logic at, input mem_size_e sz,
                             input atomic_op_e op, input addr_t a, input word_t d,
                             input reg_idx_t r, input word_t exp);
        stim_q.push_back('{st, at, sz, op, a, d, r, exp});
    endtask

    task automatic build_table();
        // Local word stores and readback including an untouched lane
        add_entry(1, 0, SIZE_W,  AMO_ADD,  32'h0000_0014, 32'hcafe_babe, 0,  32'h0);
        add_entry(1, 0, SIZE_W,  AMO_ADD,  32'h0000_0018, 32'h1234_5678, 0,  32'h0);
        add_entry(0, 0, SIZE_W,  AMO_ADD,  32'h0000_0014, 32'h0,         1,  32'hcafe_babe);
        add_entry(0, 0, SIZE_W,  AMO_ADD,  32'h0000_0018, 32'h0,         2,  32'h1234_5678);
        add_entry(0, 0, SIZE_W,  AMO_ADD,  32'h0000_001c, 32'h0,         3,  32'h3c3c_001c);
        // Global word store and subword loads
        add_entry(1, 0, SIZE_W,  AMO_ADD,  32'h8000_0040, 32'h8081_7f01, 0,  32'h0);
        add_entry(0, 0, SIZE_W,  AMO_ADD,  32'h8000_0040, 32'h0,         4,  32'h8081_7f01);
        add_entry(0, 0, SIZE_B,  AMO_ADD,  32'h8000_0041, 32'h0,         5,  32'h0000_007f);
        add_entry(0, 0, SIZE_B,  AMO_ADD,  32'h8000_0042, 32'h0,         6,  32'hffff_ff81);
        add_entry(0, 0, SIZE_BU, AMO_ADD,  32'h8000_0043, 32'h0,         7,  32'h0000_0080);
        add_entry(0, 0, SIZE_H,  AMO_ADD,  32'h8000_0042, 32'h0,         8,  32'hffff_8081);
        add_entry(0, 0, SIZE_HU, AMO_ADD,  32'h8000_0042, 32'h0,         9,  32'h0000_8081);
        add_entry(0, 0, SIZE_H,  AMO_ADD,  32'h8000_0040, 32'h0,         10, 32'h0000_7f01);
        add_entry(0, 0, SIZE_W,  AMO_ADD,  32'h8000_0048, 32'h0,         11, 32'h5a5a_0048);
        // Subword stores go through read-modify-write
        add_entry(1, 0, SIZE_B,  AMO_ADD,  32'h8000_0041, 32'haaaa_aa55, 0,  32'h0);
        add_entry(1, 0, SIZE_H,  AMO_ADD,  32'h8000_0042, 32'h1111_beef, 0,  32'h0);
        add_entry(0, 0, SIZE_W,  AMO_ADD,  32'h8000_0040, 32'h0,         12, 32'hbeef_5501);
        // Atomic chain where each returns the previous word
        add_entry(1, 0, SIZE_W,  AMO_ADD,  32'h8000_0044, 32'h0000_0010, 0,  32'h0);
        add_entry(0, 1, SIZE_W,  AMO_ADD,  32'h8000_0044, 32'h0000_0005, 13, 32'h0000_0010);
        add_entry(0, 1, SIZE_W,  AMO_MIN,  32'h8000_0044, 32'hffff_fff0, 14, 32'h0000_0015);
        add_entry(0, 1, SIZE_W,  AMO_MAX,  32'h8000_0044, 32'h0000_0003, 15, 32'hffff_fff0);
        add_entry(0, 1, SIZE_W,  AMO_XCHG, 32'h8000_0044, 32'hf0f0_00ff, 16, 32'h0000_0003);
        add_entry(0, 1, SIZE_W,  AMO_AND,  32'h8000_0044, 32'h0ff0_0f0f, 17, 32'hf0f0_00ff);
        add_entry(0, 1, SIZE_W,  AMO_OR,   32'h8000_0044, 32'h1200_3400, 18, 32'h00f0_000f);
        add_entry(0, 1, SIZE_W,  AMO_XOR,  32'h8000_0044, 32'hffff_ffff, 19, 32'h12f0_340f);
        add_entry(0, 1, SIZE_W,  AMO_KEEP, 32'h8000_0044, 32'h0000_1234, 20, 32'hed0f_cbf0);
        add_entry(0, 0, SIZE_W,  AMO_ADD,  32'h8000_0044, 32'h0,         21, 32'hed0f_cbf0);
        add_entry(0, 0, SIZE_W,  AMO_ADD,  32'h0000_0014, 32'h0,         31, 32'hcafe_babe);
    endtask

    // Holds one entry until accepted and looks for its writeback
    task automatic apply_entry(input int i);
        entry_t e;
        logic   global_op;
        logic   writes_back;
        e           = stim_q[i];
        global_op   = e.addr[`LSU_GLOBAL_BIT];
        writes_back = !e.is_store || e.is_atomic;
        @(negedge clk);
        valid_in     = 1'b1;
        is_store     = e.is_store;
        is_atomic    = e.is_atomic;
        size         = e.size;
        atomic_op    = e.op;
        addr         = e.addr;
        write_data   = e.wdata;
        dest_reg_idx = e.dest;
        @(posedge clk);
        while (stall_pipeline) begin
            if (wb_valid) flag_entry(i, "writeback seen while the pipeline was stalled");
            @(posedge clk);
        end
        if (global_op && writes_back) begin
            check_bit("busy", busy, 1'b1);  // Sequencer still finishing the access
            if (wb_valid) begin
                check_word("wb_data", wb_data, e.expected);
                check_idx("wb_reg_idx", wb_reg_idx, e.dest);
            end else begin
                flag_entry(i, "no writeback in the cycle the global access was accepted");
            end
        end else if (wb_valid) begin
            flag_entry(i, "writeback in the accept cycle of an access that has none");
        end
        @(negedge clk);
        valid_in = 1'b0;
        @(posedge clk);
        check_bit("busy", busy, !global_op && writes_back);  // Only a local read is pending
        if (!global_op && writes_back) begin
            if (wb_valid) begin
                check_word("wb_data", wb_data, e.expected);
                check_idx("wb_reg_idx", wb_reg_idx, e.dest);
            end else begin
                flag_entry(i, "no writeback one cycle after the local load");
            end
        end else if (wb_valid) begin
            flag_entry(i, "writeback one cycle after an access that has none");
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n            = 1'b0;
        valid_in         = 1'b0;
        is_store         = 1'b0;
        is_atomic        = 1'b0;
        size             = SIZE_W;
        atomic_op        = AMO_ADD;
        addr             = '0;
        write_data       = '0;
        dest_reg_idx     = '0;
        local_rdata      = '0;
        global_req_ready = 1'b0;
        global_resp_valid = 1'b0;
        global_resp_data = '0;
        lread_line       = '0;
        resp_word        = '0;
        resp_wait        = 0;
        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < `LSU_LANES; j++) begin
                lmem[i][j*`LSU_DATA_W +: `LSU_DATA_W] = 32'h3c3c_0000 | (i << 4) | (j << 2);
            end
        end
        for (int i = 0; i < 64; i++) begin
            gmem[i] = 32'h5a5a_0000 | (i << 2);  // Fill shows its byte address
        end
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("global_req_valid", global_req_valid, 1'b0);
        check_bit("local_req_valid", local_req_valid, 1'b0);
        check_bit("stall_pipeline", stall_pipeline, 1'b0);
        check_bit("busy", busy, 1'b0);
        for (int i = 0; i < stim_q.size(); i++) begin
            apply_entry(i);
        end
        while (busy) @(posedge clk);  // Wait for the last access to drain
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.sva_i.violations);
        if (errors == 0 && dut_i.sva_i.violations == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((RESET_CYCLES + stim_q.size() * CYCLES_PER_ENTRY) * CLK_PERIOD);
        $display("Watchdog expired before the stimulus table completed");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== rtl/atomic_alu.sv ====
`timescale 1ns/1ns

module atomic_alu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,      // Old word arrives this cycle
    input  lsu_pkg::atomic_op_e op,
    input  lsu_pkg::word_t      old_word,
    input  lsu_pkg::word_t      operand,
    output lsu_pkg::word_t      new_word
);
    import lsu_pkg::*;

    // op and operand come from the sequencer's issue-time capture,
    // so they stay fixed for the whole read-modify-write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_word <= '0;
        end else if (load) begin
            new_word <= atomic_apply(op, old_word, operand);
        end
    end

endmodule

// ==== rtl/global_seq.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module global_seq (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue,
    input  logic                is_store,
    input  logic                is_atomic,
    input  lsu_pkg::mem_size_e  size,
    input  lsu_pkg::atomic_op_e atomic_op,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::word_t      write_data,
    input  lsu_pkg::reg_idx_t   dest_reg_idx,
    mem_req_if.seq              mem,
    output logic                stall,
    output lsu_pkg::seq_state_e state,
    output logic                load_done,
    output logic                atomic_done,
    output lsu_pkg::reg_idx_t   pend_idx,
    output lsu_pkg::mem_size_e  pend_size,
    output logic [1:0]          pend_offset,
    output lsu_pkg::word_t      old_word
);
    import lsu_pkg::*;

    addr_t      aligned_addr;
    addr_t      pend_addr;
    word_t      pend_data;      // Store data or atomic operand
    atomic_op_e pend_op;
    word_t      merged_word;
    word_t      new_word;
    logic       word_store;
    logic       xfer;

    assign aligned_addr = {addr[`LSU_ADDR_W-1:2], 2'b00};
    assign word_store   = is_store && !is_atomic && (size == SIZE_W);
    assign xfer         = mem.req_valid && mem.req_ready;

    assign load_done   = (state == SEQ_LOAD_WAIT) && mem.resp_valid;
    assign atomic_done = (state == SEQ_ATOM_STORE) && xfer;

    // ------------------------------------------------------------------
    // Request drive and pipeline stall
    // ------------------------------------------------------------------
    always_comb begin
        mem.req_valid   = 1'b0;
        mem.req_is_load = 1'b1;
        mem.req_addr    = pend_addr;
        mem.req_wdata   = write_data;
        stall           = 1'b0;
        case (state)
            SEQ_IDLE: begin
                // First request comes straight from the held pipeline inputs
                mem.req_valid   = issue;
                mem.req_is_load = !word_store;  // Everything but SW reads first
                mem.req_addr    = aligned_addr;
                stall           = issue && !(word_store && mem.req_ready);
            end
            SEQ_LOAD_WAIT: begin
                stall = !mem.resp_valid;  // Accepted with its response
            end
            SEQ_RMW_LOAD, SEQ_ATOM_LOAD: begin
                stall = 1'b1;
            end
            SEQ_RMW_STORE, SEQ_ATOM_STORE: begin
                mem.req_valid   = 1'b1;
                mem.req_is_load = 1'b0;
                mem.req_wdata   = (state == SEQ_RMW_STORE) ? merged_word : new_word;
                stall           = !mem.req_ready;
            end
            default: begin
                stall = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (xfer && !word_store) begin
                        if (is_atomic) begin
                            state <= SEQ_ATOM_LOAD;
                        end else if (is_store) begin
                            state <= SEQ_RMW_LOAD;   // SB or SH
                        end else begin
                            state <= SEQ_LOAD_WAIT;
                        end
                    end
                end
                SEQ_LOAD_WAIT: if (mem.resp_valid) state <= SEQ_IDLE;
                SEQ_RMW_LOAD:  if (mem.resp_valid) state <= SEQ_RMW_STORE;
                SEQ_ATOM_LOAD: if (mem.resp_valid) state <= SEQ_ATOM_STORE;
                SEQ_RMW_STORE, SEQ_ATOM_STORE: begin
                    if (xfer) state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Captured payload of the access in flight
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && xfer) begin
            pend_addr   <= aligned_addr;
            pend_idx    <= dest_reg_idx;
            pend_size   <= size;
            pend_offset <= addr[1:0];
            pend_data   <= write_data;
            pend_op     <= atomic_op;
        end
        if (state == SEQ_RMW_LOAD && mem.resp_valid) begin
            merged_word <= merge_subword(mem.resp_data, pend_size, pend_offset, pend_data);
        end
        if (state == SEQ_ATOM_LOAD && mem.resp_valid) begin
            old_word <= mem.resp_data;  // Returned to the register file
        end
    end

    atomic_alu alu_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (state == SEQ_ATOM_LOAD && mem.resp_valid),
        .op       (pend_op),
        .old_word (mem.resp_data),
        .operand  (pend_data),
        .new_word (new_word)
    );

endmodule

// ==== rtl/local_port.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module local_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  logic              is_store,
    input  lsu_pkg::addr_t    addr,
    input  lsu_pkg::word_t    write_data,
    input  lsu_pkg::reg_idx_t dest_reg_idx,
    output logic              local_req_valid,
    output logic              local_we,
    output lsu_pkg::addr_t    local_addr,
    output lsu_pkg::line_t    local_wdata,
    output logic [1:0]        local_bank_sel,
    output logic              rd_pending,
    output lsu_pkg::reg_idx_t rd_idx,
    output logic [1:0]        rd_lane
);
    logic rd_issue;

    assign rd_issue = issue && !is_store;

    // BRAM request goes out in the accept cycle
    assign local_req_valid = issue;
    assign local_we        = issue && is_store;
    assign local_addr      = addr;
    assign local_wdata     = {`LSU_LANES{write_data}};  // bank_sel picks the lane written
    assign local_bank_sel  = addr[3:2];                 // Word within the 16-byte line

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_issue;  // Read data valid next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rd_idx  <= dest_reg_idx;
            rd_lane <= addr[3:2];
        end
    end

endmodule

// ==== rtl/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Datapath widths
`define LSU_ADDR_W      32
`define LSU_DATA_W      32
`define LSU_REG_IDX_W   5

// Address map and local BRAM shape
`define LSU_GLOBAL_BIT  31  // Set selects global memory
`define LSU_LANES       4   // 32-bit lanes per BRAM line

`endif

// ==== rtl/lsu_pkg.sv ====
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_ADDR_W-1:0]            addr_t;
    typedef logic [`LSU_DATA_W-1:0]            word_t;
    typedef logic [`LSU_LANES*`LSU_DATA_W-1:0] line_t;
    typedef logic [`LSU_REG_IDX_W-1:0]         reg_idx_t;

    // RISC-V funct3 access size
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } mem_size_e;

    typedef enum logic [2:0] {
        AMO_ADD  = 3'd0,
        AMO_MIN  = 3'd1,  // Signed
        AMO_MAX  = 3'd2,  // Signed
        AMO_XCHG = 3'd3,
        AMO_KEEP = 3'd4,
        AMO_AND  = 3'd5,
        AMO_OR   = 3'd6,
        AMO_XOR  = 3'd7
    } atomic_op_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD_WAIT,
        SEQ_RMW_LOAD,
        SEQ_RMW_STORE,
        SEQ_ATOM_LOAD,
        SEQ_ATOM_STORE
    } seq_state_e;

    // ------------------------------------------------------------------
    // Subword helpers
    // ------------------------------------------------------------------
    function automatic word_t extract_subword(input word_t w, input mem_size_e size,
                                              input logic [1:0] offset);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[offset*8 +: 8];
        h = w[offset[1]*16 +: 16];
        case (size)
            SIZE_B:  return {{(`LSU_DATA_W-8){b[7]}}, b};
            SIZE_H:  return {{(`LSU_DATA_W-16){h[15]}}, h};
            SIZE_BU: return {{(`LSU_DATA_W-8){1'b0}}, b};
            SIZE_HU: return {{(`LSU_DATA_W-16){1'b0}}, h};
            default: return w;  // Word
        endcase
    endfunction

    function automatic word_t merge_subword(input word_t old_w, input mem_size_e size,
                                            input logic [1:0] offset, input word_t data);
        word_t merged;
        merged = old_w;
        case (size)
            SIZE_B, SIZE_BU: merged[offset*8 +: 8]      = data[7:0];
            SIZE_H, SIZE_HU: merged[offset[1]*16 +: 16] = data[15:0];
            default:         merged                     = data;
        endcase
        return merged;
    endfunction

    function automatic word_t atomic_apply(input atomic_op_e op, input word_t old_w,
                                           input word_t opnd);
        case (op)
            AMO_ADD:  return old_w + opnd;
            AMO_MIN:  return ($signed(old_w) < $signed(opnd)) ? old_w : opnd;
            AMO_MAX:  return ($signed(old_w) > $signed(opnd)) ? old_w : opnd;
            AMO_XCHG: return opnd;
            AMO_AND:  return old_w & opnd;
            AMO_OR:   return old_w | opnd;
            AMO_XOR:  return old_w ^ opnd;
            AMO_KEEP: return old_w;
        endcase
    endfunction

endpackage

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_top (
    input  logic                clk,
    input  logic                rst_n,
    // Pipeline
    input  logic                valid_in,
    input  logic                is_store,
    input  logic                is_atomic,
    input  lsu_pkg::mem_size_e  size,
    input  lsu_pkg::atomic_op_e atomic_op,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::word_t      write_data,
    input  lsu_pkg::reg_idx_t   dest_reg_idx,
    output logic                stall_pipeline,
    output logic                busy,
    // Local shared BRAM
    output logic                local_req_valid,
    output logic                local_we,
    output lsu_pkg::addr_t      local_addr,
    output lsu_pkg::line_t      local_wdata,
    output logic [1:0]          local_bank_sel,
    input  lsu_pkg::line_t      local_rdata,
    // Global memory
    output logic                global_req_valid,
    output logic                global_req_is_load,
    output lsu_pkg::addr_t      global_req_addr,
    output lsu_pkg::word_t      global_req_wdata,
    input  logic                global_req_ready,
    input  logic                global_resp_valid,
    input  lsu_pkg::word_t      global_resp_data,
    // Register file writeback
    output logic                wb_valid,
    output lsu_pkg::reg_idx_t   wb_reg_idx,
    output lsu_pkg::word_t      wb_data
);
    import lsu_pkg::*;

    logic       is_global;
    logic       rd_pending;
    reg_idx_t   rd_idx;
    logic [1:0] rd_lane;
    seq_state_e seq_state;
    logic       load_done;
    logic       atomic_done;
    reg_idx_t   pend_idx;
    mem_size_e  pend_size;
    logic [1:0] pend_offset;
    word_t      old_word;

    mem_req_if mem_i ();

    assign is_global = addr[`LSU_GLOBAL_BIT];

    // ------------------------------------------------------------------
    // Global pins to request interface
    // ------------------------------------------------------------------
    assign global_req_valid   = mem_i.req_valid;
    assign global_req_is_load = mem_i.req_is_load;
    assign global_req_addr    = mem_i.req_addr;
    assign global_req_wdata   = mem_i.req_wdata;
    assign mem_i.req_ready    = global_req_ready;
    assign mem_i.resp_valid   = global_resp_valid;
    assign mem_i.resp_data    = global_resp_data;

    assign busy = rd_pending || (seq_state != SEQ_IDLE);

    local_port local_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .issue           (valid_in && !is_global),  // Local side never stalls
        .is_store        (is_store),
        .addr            (addr),
        .write_data      (write_data),
        .dest_reg_idx    (dest_reg_idx),
        .local_req_valid (local_req_valid),
        .local_we        (local_we),
        .local_addr      (local_addr),
        .local_wdata     (local_wdata),
        .local_bank_sel  (local_bank_sel),
        .rd_pending      (rd_pending),
        .rd_idx          (rd_idx),
        .rd_lane         (rd_lane)
    );

    global_seq seq_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (valid_in && is_global),
        .is_store     (is_store),
        .is_atomic    (is_atomic),
        .size         (size),
        .atomic_op    (atomic_op),
        .addr         (addr),
        .write_data   (write_data),
        .dest_reg_idx (dest_reg_idx),
        .mem          (mem_i),
        .stall        (stall_pipeline),
        .state        (seq_state),
        .load_done    (load_done),
        .atomic_done  (atomic_done),
        .pend_idx     (pend_idx),
        .pend_size    (pend_size),
        .pend_offset  (pend_offset),
        .old_word     (old_word)
    );

    wb_mux wb_i (
        .rd_pending  (rd_pending),
        .rd_idx      (rd_idx),
        .rd_lane     (rd_lane),
        .local_rdata (local_rdata),
        .load_done   (load_done),
        .atomic_done (atomic_done),
        .pend_idx    (pend_idx),
        .pend_size   (pend_size),
        .pend_offset (pend_offset),
        .resp_data   (global_resp_data),
        .old_word    (old_word),
        .wb_valid    (wb_valid),
        .wb_reg_idx  (wb_reg_idx),
        .wb_data     (wb_data)
    );

endmodule

// ==== rtl/mem_req_if.sv ====
`timescale 1ns/1ns

interface mem_req_if;
    import lsu_pkg::*;

    logic  req_valid;
    logic  req_is_load;
    addr_t req_addr;
    word_t req_wdata;
    logic  req_ready;
    logic  resp_valid;  // One-cycle pulse per load
    word_t resp_data;

    // Sequencer side
    modport seq (
        output req_valid, req_is_load, req_addr, req_wdata,
        input  req_ready, resp_valid, resp_data
    );

    // Memory side, tied to the top-level pins
    modport port (
        input  req_valid, req_is_load, req_addr, req_wdata,
        output req_ready, resp_valid, resp_data
    );

endinterface

// ==== rtl/wb_mux.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module wb_mux (
    input  logic               rd_pending,
    input  lsu_pkg::reg_idx_t  rd_idx,
    input  logic [1:0]         rd_lane,
    input  lsu_pkg::line_t     local_rdata,
    input  logic               load_done,
    input  logic               atomic_done,
    input  lsu_pkg::reg_idx_t  pend_idx,
    input  lsu_pkg::mem_size_e pend_size,
    input  logic [1:0]         pend_offset,
    input  lsu_pkg::word_t     resp_data,
    input  lsu_pkg::word_t     old_word,
    output logic               wb_valid,
    output lsu_pkg::reg_idx_t  wb_reg_idx,
    output lsu_pkg::word_t     wb_data
);
    import lsu_pkg::*;

    word_t local_word;

    assign local_word = local_rdata[rd_lane*`LSU_DATA_W +: `LSU_DATA_W];

    always_comb begin
        wb_valid   = 1'b0;
        wb_reg_idx = '0;
        wb_data    = '0;
        if (atomic_done) begin
            wb_valid   = 1'b1;
            wb_reg_idx = pend_idx;
            wb_data    = old_word;  // Atomics return the value before the update
        end else if (load_done) begin
            wb_valid   = 1'b1;
            wb_reg_idx = pend_idx;
            wb_data    = extract_subword(resp_data, pend_size, pend_offset);
        end else if (rd_pending) begin
            wb_valid   = 1'b1;
            wb_reg_idx = rd_idx;
            wb_data    = local_word;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f all.f -Mdir obj_dir

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/Vlsu_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
